// File: src.f
src/fixFormatPkg.sv
src/filterCoefPkg.sv
src/batchRam.sv
src/sampleBatcher.sv
src/recursionLane.sv
src/batchEngine.sv
src/resultMerger.sv
src/reconTop.sv
tb/reconTop_asserts.sv
tb/reconTb.sv

// File: tb/reconTb.sv
`timescale 1ns/1ps

module reconTb
    import fixFormatPkg::*;
    import filterCoefPkg::*;
();

    localparam int ResetCycles = 16;
    localparam int LongStall = 400;
    localparam int IdleCycles = 6 * Depth;
    localparam int NumRows = 7;

    localparam int PatZeros = 0;
    localparam int PatOnes = 1;
    localparam int PatAlt = 2;
    localparam int PatLfsr = 3;
    localparam int GapNone = 0;
    localparam int GapRandom = 1;
    localparam int StallNone = 0;
    localparam int StallRandom = 1;
    localparam int StallLong = 2;

    typedef struct packed {
        int kind;
        int batches;
        int gap;
        int stall;
    } stimRow;

    // Pattern, batches, inValid gaps, outReady stalls
    localparam stimRow StimTable [NumRows] = '{
        '{PatZeros, 3, GapNone, StallNone},
        '{PatOnes, 4, GapNone, StallNone},
        '{PatAlt, 8, GapNone, StallNone},
        '{PatLfsr, 8, GapNone, StallNone},
        '{PatLfsr, 8, GapRandom, StallNone},
        '{PatLfsr, 8, GapNone, StallRandom},
        '{PatLfsr, 8, GapRandom, StallLong}};

    logic               clkDS = 1'b0;
    logic               rst;
    logic [InWidth-1:0] inData;
    logic               inValid;
    logic               inReady;
    fixWord             outData;
    logic               outValid;
    logic               outReady;

    logic [31:0]        lfsrState;
    logic [InWidth-1:0] rowSamples [$];
    fixWord             expectQ [$];
    int                 errorCount = 0;
    int                 cycleCount = 0;
    int                 cycleLimit = 0;

    reconTop i_dut (
        .clkDS(clkDS),
        .rst(rst),
        .inData(inData),
        .inValid(inValid),
        .inReady(inReady),
        .outData(outData),
        .outValid(outValid),
        .outReady(outReady)
    );

    always #10 clkDS = ~clkDS;

    task automatic stopWithError(input string what);
        errorCount++;
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    always @(posedge clkDS) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            stopWithError($sformatf("Simulation timed out after %0d cycles", cycleCount));
        end
    end

    always @(negedge clkDS) begin
        if (i_dut.protocolChecks.failCount != 0) begin
            stopWithError("A stream protocol assertion on the output failed");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic nextRandBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    // Q8.16 product truncated toward minus infinity and wrapped to 24 bits
    function automatic fixWord scaleMul(input fixWord a, input fixWord b);
        longint prod;
        prod = longint'(a) * longint'(b);
        prod = prod >>> FracBits;
        return fixWord'(prod);
    endfunction

    function automatic cplxWord recurStep(input cplxWord pole, input cplxWord st,
                                          input logic [InWidth-1:0] bits, input int lane,
                                          input logic useFwd);
        cplxWord nxt;
        cplxWord g;
        nxt.re = scaleMul(pole.re, st.re) - scaleMul(pole.im, st.im);
        nxt.im = scaleMul(pole.re, st.im) + scaleMul(pole.im, st.re);
        for (int b = 0; b < InWidth; b++) begin
            g = useFwd ? gammaF[lane][b] : gammaB[lane][b];
            if (bits[b]) begin
                nxt.re = nxt.re + g.re;
                nxt.im = nxt.im + g.im;
            end else begin
                nxt.re = nxt.re - g.re;
                nxt.im = nxt.im - g.im;
            end
        end
        return nxt;
    endfunction

    function automatic fixWord weightedReal(input cplxWord w, input cplxWord st);
        return scaleMul(w.re, st.re) - scaleMul(w.im, st.im);
    endfunction

    // Expected outputs for batches 0 .. batches-3 of the current row
    function automatic void modelRow(input int batches);
        cplxWord fwdSt [Lanes];
        cplxWord bwdSt [Lanes];
        fixWord  fwdRes [Depth];
        fixWord  bwdRes [Depth];
        int      base;
        for (int l = 0; l < Lanes; l++) begin
            fwdSt[l] = '0;
        end
        for (int q = 0; q <= batches - 3; q++) begin
            base = q * Depth;
            for (int k = 0; k < Depth; k++) begin
                fwdRes[k] = '0;
                for (int l = 0; l < Lanes; l++) begin
                    fwdSt[l] = recurStep(lambdaF[l], fwdSt[l], rowSamples[base + k], l, 1'b1);
                    fwdRes[k] = fwdRes[k] + weightedReal(weightF[l], fwdSt[l]);
                end
            end
            // Seed is the reversed run over the following batch
            for (int l = 0; l < Lanes; l++) begin
                bwdSt[l] = '0;
                for (int k = Depth - 1; k >= 0; k--) begin
                    bwdSt[l] = recurStep(lambdaB[l], bwdSt[l], rowSamples[base + Depth + k],
                                         l, 1'b0);
                end
            end
            for (int k = Depth - 1; k >= 0; k--) begin
                bwdRes[k] = '0;
                for (int l = 0; l < Lanes; l++) begin
                    bwdSt[l] = recurStep(lambdaB[l], bwdSt[l], rowSamples[base + k], l, 1'b0);
                    bwdRes[k] = bwdRes[k] + weightedReal(weightB[l], bwdSt[l]);
                end
            end
            for (int k = 0; k < Depth; k++) begin
                expectQ.push_back(fwdRes[k] + bwdRes[k]);
            end
        end
    endfunction

    task automatic buildSamples(input int kind, input int batches);
        logic [InWidth-1:0] s;
        rowSamples.delete();
        for (int i = 0; i < batches * Depth; i++) begin
            case (kind)
                PatZeros: s = '0;
                PatOnes:  s = '1;
                PatAlt:   s = (i % 2 == 0) ? 3'b101 : 3'b010;
                default: begin
                    for (int b = 0; b < InWidth; b++) begin
                        s[b] = nextRandBit();
                    end
                end
            endcase
            rowSamples.push_back(s);
        end
    endtask

    task automatic resetDut();
        rst = 1'b0;
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        repeat (ResetCycles - 1) @(posedge clkDS);
        @(negedge clkDS);
        assert (!outValid && !inReady) else begin
            stopWithError("outValid or inReady was high at the end of reset");
        end
        @(posedge clkDS);
        #2;
        rst = 1'b1;
    endtask

    task automatic checkOutput();
        fixWord expVal;
        if (expectQ.size() == 0) begin
            stopWithError("An output transfer arrived with no result left to expect");
        end
        expVal = expectQ.pop_front();
        assert (outData === expVal) else begin
            stopWithError($sformatf("FAIL time=%0t outData expected=%0d actual=%0d",
                                    $time, expVal, outData));
        end
    endtask

    task automatic runRow(input stimRow row);
        int   nextIdx;
        int   rowCycle;
        int   total;
        logic inAcc;
        logic outAcc;
        nextIdx = 0;
        rowCycle = 0;
        total = row.batches * Depth;
        buildSamples(row.kind, row.batches);
        modelRow(row.batches);
        while (expectQ.size() > 0 || nextIdx < total) begin
            // Values seen here are the ones the next rising edge transfers
            @(negedge clkDS);
            inAcc = inValid && inReady;
            outAcc = outValid && outReady;
            if (outValid && nextIdx < 3 * Depth) begin
                stopWithError("An output appeared before three batches were sent");
            end
            if (row.stall == StallLong && rowCycle == LongStall - 1) begin
                assert (!inReady && outValid) else begin
                    stopWithError("inReady stayed high through a long output stall");
                end
            end
            if (outAcc) begin
                checkOutput();
            end
            if (inAcc) begin
                nextIdx++;
            end
            @(posedge clkDS);
            #2;
            if (!inValid || inAcc) begin
                if (nextIdx < total) begin
                    inData = rowSamples[nextIdx];
                    inValid = (row.gap == GapRandom) ? nextRandBit() : 1'b1;
                end else begin
                    inValid = 1'b0;
                end
            end
            case (row.stall)
                StallRandom: outReady = nextRandBit();
                StallLong:   outReady = (rowCycle >= LongStall - 1);
                default:     outReady = 1'b1;
            endcase
            rowCycle++;
        end
        // Nothing more may come out once the row is complete
        outReady = 1'b1;
        repeat (IdleCycles) begin
            @(negedge clkDS);
            if (outValid) begin
                stopWithError("An extra output appeared after the row was complete");
            end
        end
        @(posedge clkDS);
        #2;
    endtask

    initial begin
        int totalSamples;
        rst = 1'b0;
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        lfsrState = 32'd83710;
        totalSamples = 0;
        for (int r = 0; r < NumRows; r++) begin
            totalSamples += StimTable[r].batches * Depth;
        end
        cycleLimit = 12 * totalSamples + 200;
        for (int r = 0; r < NumRows; r++) begin
            resetDut();
            runRow(StimTable[r]);
        end
        if (errorCount == 0 && i_dut.protocolChecks.failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/reconTop_asserts.sv
`timescale 1ns/1ps

module streamProtocolChecks
    import fixFormatPkg::*;
(
    input logic   clkDS,
    input logic   rst,
    input fixWord outData,
    input logic   outValid,
    input logic   outReady
);

    int failCount = 0;

    // A result offered but not taken must still be offered next cycle
    assert property (@(posedge clkDS) disable iff (!rst)
        (outValid && !outReady) |=> outValid)
        else begin
            failCount++;
            $error("outValid dropped before the transfer");
        end

    assert property (@(posedge clkDS) disable iff (!rst)
        (outValid && !outReady) |=> $stable(outData))
        else begin
            failCount++;
            $error("outData changed while the output was stalled");
        end

    assert property (@(posedge clkDS) !rst |=> !outValid)
        else begin
            failCount++;
            $error("outValid high during reset");
        end

endmodule

bind reconTop streamProtocolChecks protocolChecks (
    .clkDS(clkDS),
    .rst(rst),
    .outData(outData),
    .outValid(outValid),
    .outReady(outReady)
);

// File: src/reconTop.sv
`timescale 1ns/1ps

module reconTop
    import fixFormatPkg::*;
    import filterCoefPkg::*;
(
    input  logic               clkDS,
    input  logic               rst,
    input  logic [InWidth-1:0] inData,
    input  logic               inValid,
    output logic               inReady,
    output fixWord             outData,
    output logic               outValid,
    input  logic               outReady
);

    logic [RingAddrWidth-1:0] ringReadAddr;
    logic [InWidth-1:0]       ringReadData;
    logic [CountWidth-1:0]    batchCount;
    logic                     slotRelease;
    logic                     bankFree;
    fixWord                   fwdSum;
    fixWord                   bwdSum;
    logic                     contribValid;
    logic                     passLive;

    sampleBatcher batcher (
        .clkDS(clkDS),
        .rst(rst),
        .inData(inData),
        .inValid(inValid),
        .inReady(inReady),
        .ringReadAddr(ringReadAddr),
        .ringReadData(ringReadData),
        .batchCount(batchCount),
        .slotRelease(slotRelease)
    );

    batchEngine engine (
        .clkDS(clkDS),
        .rst(rst),
        .batchCount(batchCount),
        .slotRelease(slotRelease),
        .ringReadAddr(ringReadAddr),
        .ringReadData(ringReadData),
        .bankFree(bankFree),
        .fwdSum(fwdSum),
        .bwdSum(bwdSum),
        .contribValid(contribValid),
        .passLive(passLive)
    );

    resultMerger merger (
        .clkDS(clkDS),
        .rst(rst),
        .fwdSum(fwdSum),
        .bwdSum(bwdSum),
        .contribValid(contribValid),
        .passLive(passLive),
        .bankFree(bankFree),
        .outData(outData),
        .outValid(outValid),
        .outReady(outReady)
    );

endmodule

// File: src/resultMerger.sv
`timescale 1ns/1ps

module resultMerger
    import fixFormatPkg::*;
    import filterCoefPkg::*;
(
    input  logic   clkDS,
    input  logic   rst,
    input  fixWord fwdSum,
    input  fixWord bwdSum,
    input  logic   contribValid,
    input  logic   passLive,
    output logic   bankFree,
    output fixWord outData,
    output logic   outValid,
    input  logic   outReady
);

    logic [1:0]           bankFull;
    logic                 fillBank;
    logic [StepWidth-1:0] fillIdx;
    logic                 fillWr;
    logic                 fillEnd;
    logic                 drainBank;
    logic [StepWidth-1:0] drainIdx;
    logic                 rdPend;
    logic                 bankReady;
    logic                 issue;
    logic                 canLoad;
    logic                 loadOut;
    logic                 bypassSel;
    fixWord               bwdLast;
    fixWord               bwdWord;
    logic [StepWidth-1:0] rdAddr;
    fixWord               fwdRd [2];
    fixWord               bwdRd [2];

    assign fillWr = contribValid && passLive;
    assign fillEnd = fillWr && (fillIdx == StepWidth'(Depth - 1));
    assign bankFree = !bankFull[fillBank];

    // Drain may start on the cycle the last word is written
    assign bankReady = bankFull[drainBank] || (fillEnd && fillBank == drainBank);
    assign issue = !rdPend && bankReady;
    assign canLoad = !outValid || outReady;
    assign loadOut = rdPend && canLoad;
    assign rdAddr = loadOut ? drainIdx + 1'b1 : drainIdx;

    // Mirrored word 0 is still being written when the first read issues
    assign bwdWord = bypassSel ? bwdLast : bwdRd[drainBank];

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            bankFull <= '0;
            fillBank <= 1'b0;
            fillIdx <= '0;
            drainBank <= 1'b0;
            drainIdx <= '0;
            rdPend <= 1'b0;
            bypassSel <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (fillWr) begin
                fillIdx <= fillIdx + 1'b1;
            end
            if (fillEnd) begin
                bankFull[fillBank] <= 1'b1;
                fillBank <= !fillBank;
            end
            bypassSel <= issue && !bankFull[drainBank];
            if (issue) begin
                rdPend <= 1'b1;
            end
            if (loadOut) begin
                outValid <= 1'b1;
                drainIdx <= drainIdx + 1'b1;
                if (drainIdx == StepWidth'(Depth - 1)) begin
                    rdPend <= 1'b0;
                    bankFull[drainBank] <= 1'b0;
                    drainBank <= !drainBank;
                end
            end else if (outReady) begin
                outValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (fillWr) begin
            bwdLast <= bwdSum;
        end
        if (loadOut) begin
            outData <= fwdRd[drainBank] + bwdWord;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : gBank
        batchRam #(
            .payloadType(fixWord),
            .Entries(Depth)
        ) fwdMem (
            .clkDS(clkDS),
            .wrEn(fillWr && fillBank == b),
            .wrAddr(fillIdx),
            .wrData(fwdSum),
            .rdAddr(rdAddr),
            .rdData(fwdRd[b])
        );

        // Backward results arrive in reverse sample order
        batchRam #(
            .payloadType(fixWord),
            .Entries(Depth)
        ) bwdMem (
            .clkDS(clkDS),
            .wrEn(fillWr && fillBank == b),
            .wrAddr(StepWidth'(Depth - 1) - fillIdx),
            .wrData(bwdSum),
            .rdAddr(rdAddr),
            .rdData(bwdRd[b])
        );
    end

endmodule

// File: src/batchEngine.sv
`timescale 1ns/1ps

module batchEngine
    import fixFormatPkg::*;
    import filterCoefPkg::*;
(
    input  logic                     clkDS,
    input  logic                     rst,
    input  logic [CountWidth-1:0]    batchCount,
    output logic                     slotRelease,
    output logic [RingAddrWidth-1:0] ringReadAddr,
    input  logic [InWidth-1:0]       ringReadData,
    input  logic                     bankFree,
    output fixWord                   fwdSum,
    output fixWord                   bwdSum,
    output logic                     contribValid,
    output logic                     passLive
);

    logic                 busy;
    logic                 live;
    logic                 firstDone;
    logic                 fwdRun;
    logic [1:0]           rdPhase;
    logic [StepWidth-1:0] stepIdx;
    logic [SlotWidth-1:0] rdSlot;
    logic                 readD;
    logic [1:0]           phaseD;
    logic                 liveD;
    logic                 stepEn;
    logic                 passStart;
    logic                 pipe2;
    logic                 live2;
    logic                 pipeIdle;
    logic                 startPass;
    logic                 readLast;
    logic                 laneRst;
    logic [InWidth-1:0]   fwdBitsReg;
    logic [InWidth-1:0]   bwdBitsReg;
    logic [SlotWidth-1:0] slotSel;
    logic [StepWidth-1:0] idxSel;
    fixWord               fwdLane [Lanes];
    fixWord               bwdLane [Lanes];

    // A new pass waits for the previous one to leave the lane pipeline
    assign pipeIdle = !busy && !stepEn && !pipe2 && !contribValid;
    assign startPass = pipeIdle && (firstDone ?
        (bankFree && batchCount >= CountWidth'(3)) : (batchCount >= CountWidth'(2)));

    assign readLast = busy && (rdPhase == 2'd2);
    assign passStart = busy && (rdPhase == 2'd0) && (stepIdx == '0);
    assign slotRelease = readLast && live && (stepIdx == StepWidth'(Depth - 1));

    // Phase 0 forward, phase 1 backward, phase 2 lookahead
    always_comb begin
        slotSel = rdSlot;
        idxSel = StepWidth'(Depth - 1) - stepIdx;
        if (rdPhase == 2'd0) begin
            idxSel = stepIdx;
        end else if (rdPhase == 2'd2) begin
            slotSel = rdSlot + (live ? SlotWidth'(2) : SlotWidth'(1));
        end
    end
    assign ringReadAddr = {slotSel, idxSel};

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            busy <= 1'b0;
            live <= 1'b0;
            firstDone <= 1'b0;
            fwdRun <= 1'b0;
            rdPhase <= '0;
            stepIdx <= '0;
            rdSlot <= '0;
            readD <= 1'b0;
            phaseD <= '0;
            liveD <= 1'b0;
            pipe2 <= 1'b0;
            live2 <= 1'b0;
            contribValid <= 1'b0;
            passLive <= 1'b0;
        end else begin
            if (startPass) begin
                busy <= 1'b1;
                live <= firstDone;
                firstDone <= 1'b1;
                fwdRun <= fwdRun || firstDone;
                rdPhase <= '0;
                stepIdx <= '0;
            end else if (busy) begin
                rdPhase <= (rdPhase == 2'd2) ? 2'd0 : rdPhase + 1'b1;
                if (readLast) begin
                    stepIdx <= stepIdx + 1'b1;
                    busy <= (stepIdx != StepWidth'(Depth - 1));
                end
            end
            if (slotRelease) begin
                rdSlot <= rdSlot + 1'b1;
            end
            readD <= busy;
            phaseD <= rdPhase;
            liveD <= live;
            pipe2 <= stepEn;
            live2 <= stepEn && liveD;
            contribValid <= pipe2;
            passLive <= live2;
        end
    end

    // Bits from the first two reads wait for the lookahead read
    always_ff @(posedge clkDS) begin
        if (readD && phaseD == 2'd0) begin
            fwdBitsReg <= ringReadData;
        end
        if (readD && phaseD == 2'd1) begin
            bwdBitsReg <= ringReadData;
        end
    end

    assign stepEn = readD && (phaseD == 2'd2);

    // Forward and backward states stay at zero until the first live pass
    assign laneRst = rst && fwdRun;

    for (genvar i = 0; i < Lanes; i++) begin : gLane
        recursionLane #(
            .laneIndex(i)
        ) lane (
            .clkDS(clkDS),
            .rst(laneRst),
            .stepEn(stepEn),
            .passStart(passStart),
            .fwdBits(fwdBitsReg),
            .bwdBits(bwdBitsReg),
            .lookBits(ringReadData),
            .fwdOut(fwdLane[i]),
            .bwdOut(bwdLane[i])
        );
    end

    always_comb begin
        fwdSum = '0;
        bwdSum = '0;
        for (int i = 0; i < Lanes; i++) begin
            fwdSum = fwdSum + fwdLane[i];
            bwdSum = bwdSum + bwdLane[i];
        end
    end

endmodule

// File: src/recursionLane.sv
`timescale 1ns/1ps

module recursionLane
    import fixFormatPkg::*;
    import filterCoefPkg::*;
#(
    parameter int laneIndex = 0
) (
    input  logic               clkDS,
    input  logic               rst,
    input  logic               stepEn,
    input  logic               passStart,
    input  logic [InWidth-1:0] fwdBits,
    input  logic [InWidth-1:0] bwdBits,
    input  logic [InWidth-1:0] lookBits,
    output fixWord             fwdOut,
    output fixWord             bwdOut
);

    cplxWord fwdState;
    cplxWord bwdState;
    cplxWord lookState;
    cplxWord fwdWeighted;
    cplxWord bwdWeighted;

    // Sum of gains, sign set by each control bit
    function automatic cplxWord inputTerm(input logic [InWidth-1:0] bits, input logic useFwd);
        cplxWord acc;
        cplxWord g;
        acc = '0;
        for (int b = 0; b < InWidth; b++) begin
            g = useFwd ? gammaF[laneIndex][b] : gammaB[laneIndex][b];
            if (!bits[b]) begin
                g.re = -g.re;
                g.im = -g.im;
            end
            acc = cplxAdd(acc, g);
        end
        return acc;
    endfunction

    assign fwdWeighted = cplxMul(weightF[laneIndex], fwdState);
    assign bwdWeighted = cplxMul(weightB[laneIndex], bwdState);

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fwdState <= '0;
            bwdState <= '0;
            fwdOut <= '0;
            bwdOut <= '0;
        end else begin
            if (stepEn) begin
                fwdState <= cplxAdd(cplxMul(lambdaF[laneIndex], fwdState),
                                    inputTerm(fwdBits, 1'b1));
            end
            // Backward run starts where the lookahead over the next batch ended
            if (passStart) begin
                bwdState <= lookState;
            end else if (stepEn) begin
                bwdState <= cplxAdd(cplxMul(lambdaB[laneIndex], bwdState),
                                    inputTerm(bwdBits, 1'b0));
            end
            fwdOut <= fwdWeighted.re;
            bwdOut <= bwdWeighted.re;
        end
    end

    // Lookahead keeps its end state until the next pass begins
    always_ff @(posedge clkDS) begin
        if (passStart) begin
            lookState <= '0;
        end else if (stepEn) begin
            lookState <= cplxAdd(cplxMul(lambdaB[laneIndex], lookState),
                                 inputTerm(lookBits, 1'b0));
        end
    end

endmodule

// File: src/sampleBatcher.sv
`timescale 1ns/1ps

module sampleBatcher
    import filterCoefPkg::*;
(
    input  logic                     clkDS,
    input  logic                     rst,
    input  logic [InWidth-1:0]       inData,
    input  logic                     inValid,
    output logic                     inReady,
    input  logic [RingAddrWidth-1:0] ringReadAddr,
    output logic [InWidth-1:0]       ringReadData,
    output logic [CountWidth-1:0]    batchCount,
    input  logic                     slotRelease
);

    logic [SlotWidth-1:0]  wrSlot;
    logic [StepWidth-1:0]  wrIdx;
    logic                  accept;
    logic                  slotDone;
    logic [CountWidth-1:0] countNext;

    assign accept = inValid && inReady;
    assign slotDone = accept && (wrIdx == StepWidth'(Depth - 1));

    // Complete batches held, oldest one leaves on release
    always_comb begin
        countNext = batchCount;
        if (slotDone) begin
            countNext = countNext + 1'b1;
        end
        if (slotRelease) begin
            countNext = countNext - 1'b1;
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            wrSlot <= '0;
            wrIdx <= '0;
            batchCount <= '0;
            inReady <= 1'b0;
        end else begin
            if (accept) begin
                wrIdx <= wrIdx + 1'b1;
            end
            if (slotDone) begin
                wrSlot <= wrSlot + 1'b1;
            end
            batchCount <= countNext;
            // Slot being filled must not hold an unreleased batch
            inReady <= (countNext < CountWidth'(RingSlots));
        end
    end

    batchRam #(
        .payloadType(logic [InWidth-1:0]),
        .Entries(RingSlots * Depth)
    ) ringMem (
        .clkDS(clkDS),
        .wrEn(accept),
        .wrAddr({wrSlot, wrIdx}),
        .wrData(inData),
        .rdAddr(ringReadAddr),
        .rdData(ringReadData)
    );

endmodule

// File: src/batchRam.sv
`timescale 1ns/1ps

module batchRam #(
    parameter type payloadType = logic,
    parameter int Entries = 16
) (
    input  logic                       clkDS,
    input  logic                       wrEn,
    input  logic [$clog2(Entries)-1:0] wrAddr,
    input  payloadType                 wrData,
    input  logic [$clog2(Entries)-1:0] rdAddr,
    output payloadType                 rdData
);

    payloadType mem [Entries];

    // Read returns the old word when the same address is written
    always_ff @(posedge clkDS) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];
    end

endmodule

// File: src/filterCoefPkg.sv
package filterCoefPkg;
    import fixFormatPkg::*;

    localparam int InWidth = 3;
    localparam int Depth = 16;
    localparam int Lanes = 3;
    localparam int RingSlots = 4;

    // Derived widths for counters and ring addresses
    localparam int StepWidth = $clog2(Depth);
    localparam int SlotWidth = $clog2(RingSlots);
    localparam int RingAddrWidth = SlotWidth + StepWidth;
    localparam int CountWidth = $clog2(RingSlots + 1);

    // Poles, all of magnitude below 0.95 (1.0 = 65536)
    localparam cplxWord lambdaF [Lanes] = '{
        '{24'sd58982, 24'sd6554}, '{24'sd52429, -24'sd19661}, '{24'sd39322, 24'sd32768}};
    localparam cplxWord lambdaB [Lanes] = '{
        '{24'sd55706, -24'sd9830}, '{24'sd45875, 24'sd26214}, '{24'sd32768, -24'sd39322}};

    // Input gains, one per control bit
    localparam cplxWord gammaF [Lanes][InWidth] = '{
        '{'{24'sd1311, 24'sd655}, '{24'sd2621, -24'sd983}, '{24'sd5243, 24'sd1966}},
        '{'{24'sd983, -24'sd1311}, '{24'sd1966, 24'sd2621}, '{24'sd3932, -24'sd655}},
        '{'{24'sd655, 24'sd1966}, '{24'sd1311, -24'sd2621}, '{24'sd2621, 24'sd3277}}};
    localparam cplxWord gammaB [Lanes][InWidth] = '{
        '{'{24'sd1638, -24'sd328}, '{24'sd3277, 24'sd1311}, '{24'sd4588, -24'sd2293}},
        '{'{24'sd1311, 24'sd983}, '{24'sd2293, -24'sd1638}, '{24'sd4260, 24'sd983}},
        '{'{24'sd983, -24'sd1638}, '{24'sd1966, 24'sd2293}, '{24'sd3604, -24'sd2949}}};

    // Output weights
    localparam cplxWord weightF [Lanes] = '{
        '{24'sd16384, 24'sd3277}, '{24'sd13107, -24'sd6554}, '{24'sd9830, 24'sd8192}};
    localparam cplxWord weightB [Lanes] = '{
        '{24'sd14746, -24'sd4915}, '{24'sd11469, 24'sd5734}, '{24'sd8192, -24'sd9830}};

endpackage

// File: src/fixFormatPkg.sv
package fixFormatPkg;

    // Signed fixed point, 8 integer bits and 16 fraction bits
    localparam int WordWidth = 24;
    localparam int FracBits = 16;

    typedef logic signed [WordWidth-1:0] fixWord;

    typedef struct packed {
        fixWord re;
        fixWord im;
    } cplxWord;

    // Full product, scaled back and wrapped to the word width
    function automatic fixWord fixMul(input fixWord a, input fixWord b);
        logic signed [2*WordWidth-1:0] prod;
        prod = a * b;
        return fixWord'(prod >>> FracBits);
    endfunction

    function automatic cplxWord cplxMul(input cplxWord a, input cplxWord b);
        cplxWord res;
        res.re = fixMul(a.re, b.re) - fixMul(a.im, b.im);
        res.im = fixMul(a.re, b.im) + fixMul(a.im, b.re);
        return res;
    endfunction

    // Component-wise add, wraps on overflow
    function automatic cplxWord cplxAdd(input cplxWord a, input cplxWord b);
        cplxWord res;
        res.re = a.re + b.re;
        res.im = a.im + b.im;
        return res;
    endfunction

endpackage
